//--- all.f
+incdir+.
j1a_pkg.sv
code_bank.sv
code_ram.sv
io_decode.sv
j1a_bus.sv
tb_j1a_bus.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the j1a bus testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert -f all.f --top-module tb_j1a_bus -o tb_j1a_bus

sim_out=$(./obj_dir/tb_j1a_bus)
echo "$sim_out"

if grep -qF '** PASS **' <<< "$sim_out"; then
  exit 0
else
  exit 1
fi

//--- tb_j1a_bus.sv
`timescale 1ns/10ps
`include "j1a_defs.svh"

module tb_j1a_bus import j1a_pkg::*; ();

  localparam int RESET_CYCLES   = 16;
  localparam int STROBE_TIMEOUT = 8;
  localparam int N_CODE_WR      = 32;
  localparam int N_CODE_RD      = 64;

  logic                clk;
  logic                resetq;
  cpu_bus_t            bus;
  logic [`CODE_AW-1:0] code_addr;
  logic [`REG_W-1:0]   uart_rx_data;
  logic                uart_valid;
  logic                uart_busy;
  word_t               io_rdata;
  word_t               insn;
  logic [`LED_W-1:0]   leds;
  logic [`REG_W-1:0]   pmod_dir;
  logic [`REG_W-1:0]   hdr1_dir;
  logic [`REG_W-1:0]   hdr2_dir;
  logic [`BOOT_W-1:0]  boot_ctl;
  logic                uart_wr;
  logic                uart_rd;
  logic [`REG_W-1:0]   uart_tx;

  // reference model
  logic [`LED_W-1:0]   m_leds;
  logic [`REG_W-1:0]   m_pmod;
  logic [`REG_W-1:0]   m_hdr1;
  logic [`REG_W-1:0]   m_hdr2;
  logic [`BOOT_W-1:0]  m_boot;
  logic                m_unlocked;
  word_t               code_model [2 ** `CODE_AW];
  bit                  code_known [2 ** `CODE_AW];
  logic [`CODE_AW-1:0] written [$];

  int errors;
  int test_errors;
  int tests_run;
  int tests_failed;

  j1a_bus i_dut (
    .clk          (clk),
    .resetq       (resetq),
    .bus          (bus),
    .code_addr    (code_addr),
    .uart_rx_data (uart_rx_data),
    .uart_valid   (uart_valid),
    .uart_busy    (uart_busy),
    .io_rdata     (io_rdata),
    .insn         (insn),
    .leds         (leds),
    .pmod_dir     (pmod_dir),
    .hdr1_dir     (hdr1_dir),
    .hdr2_dir     (hdr2_dir),
    .boot_ctl     (boot_ctl),
    .uart_wr      (uart_wr),
    .uart_rd      (uart_rd),
    .uart_tx      (uart_tx)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // inputs change and outputs are sampled 1 ns after the edge
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic report_mismatch(input string msg);
    $display("[FAIL] t=%0d ns: %s", $time, msg);
    errors++;
  endtask

  task automatic check_word(input string what, input word_t got, input word_t exp);
    assert (got === exp)
      else report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == test_errors) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - test_errors);
    end
    test_errors = errors;
  endtask

  task automatic check_regs(input string when);
    check_word({when, " leds"}, word_t'(leds), word_t'(m_leds));
    check_word({when, " pmod_dir"}, word_t'(pmod_dir), word_t'(m_pmod));
    check_word({when, " hdr1_dir"}, word_t'(hdr1_dir), word_t'(m_hdr1));
    check_word({when, " hdr2_dir"}, word_t'(hdr2_dir), word_t'(m_hdr2));
    check_word({when, " boot_ctl"}, word_t'(boot_ctl), word_t'(m_boot));
    check_word({when, " unlocked"}, word_t'(i_dut.unlocked), word_t'(m_unlocked));
  endtask

  task automatic bus_idle();
    bus.io_rd  = 1'b0;
    bus.io_wr  = 1'b0;
    bus.mem_wr = 1'b0;
  endtask

  task automatic apply_reset();
    resetq = 1'b0;
    bus_idle();
    repeat (RESET_CYCLES) step();
    resetq     = 1'b1;
    m_leds     = '0;
    m_pmod     = '0;
    m_hdr1     = '0;
    m_hdr2     = '0;
    m_boot     = '0;
    m_unlocked = 1'b0;
  endtask

  task automatic io_write(input io_sel_t sel, input word_t data);
    bus.io_wr   = 1'b1;
    bus.addr.io = sel;
    bus.dout    = data;
    step();
    bus_idle();
    // still in the io stage, nothing may have moved yet
    check_regs("one edge after write");
    step();
    if (sel.leds) m_leds = data[`LED_W-1:0];
    if (sel.pmod_dir) m_pmod = data[`REG_W-1:0];
    if (sel.hdr1_dir) m_hdr1 = data[`REG_W-1:0];
    if (sel.hdr2_dir) m_hdr2 = data[`REG_W-1:0];
    if (sel.warmboot) m_boot = data[`BOOT_W-1:0];
    m_unlocked = 1'b1;
    check_regs("two edges after write");
  endtask

  task automatic io_read_check(input io_sel_t sel);
    word_t exp;
    uart_rx_data = 8'($urandom);
    uart_valid   = 1'($urandom);
    uart_busy    = 1'($urandom);
    bus.io_rd    = 1'b1;
    bus.addr.io  = sel;
    bus.dout     = word_t'($urandom);
    step();
    bus_idle();
    exp = '0;
    if (sel.pmod_dir) exp |= word_t'(m_pmod);
    if (sel.leds) exp |= word_t'(m_leds);
    if (sel.hdr1_dir) exp |= word_t'(m_hdr1);
    if (sel.hdr2_dir) exp |= word_t'(m_hdr2);
    if (sel.uart) exp |= word_t'(uart_rx_data);
    // status: not busy, valid, two fixed ones
    if (sel.misc_in) exp |= 16'h000c | word_t'({uart_valid, !uart_busy});
    check_word($sformatf("io_rdata sel %h", sel), io_rdata, exp);
    // read data holds while the bus is idle, whatever the address lines carry
    bus.addr = bus_addr_u'(16'($urandom));
    bus.dout = word_t'($urandom);
    step();
    check_word($sformatf("io_rdata held sel %h", sel), io_rdata, exp);
  endtask

  task automatic uart_access(input logic is_wr);
    word_t data;
    int    cycles;
    data             = word_t'($urandom);
    bus.addr         = '0;
    bus.addr.io.uart = 1'b1;
    bus.dout         = data;
    if (is_wr) bus.io_wr = 1'b1;
    else bus.io_rd = 1'b1;
    cycles = 0;
    do begin
      step();
      bus_idle();
      cycles++;
    end while (!(is_wr ? uart_wr : uart_rd) && cycles < STROBE_TIMEOUT);
    if (!(is_wr ? uart_wr : uart_rd)) begin
      $display("timed out waiting for a uart strobe after %0d cycles", cycles);
      errors++;
    end else begin
      assert (cycles == 1)
        else report_mismatch($sformatf("uart strobe after %0d edges, expected 1", cycles));
      check_word("other uart strobe", word_t'(is_wr ? uart_rd : uart_wr), '0);
      if (is_wr) check_word("uart_tx", word_t'(uart_tx), word_t'(data[`REG_W-1:0]));
      step();
      check_word("uart strobe one cycle later", word_t'(is_wr ? uart_wr : uart_rd), '0);
    end
    if (is_wr) m_unlocked = 1'b1;
  endtask

  task automatic code_write(input logic [`CODE_AW-1:0] a, input word_t data);
    bus.addr           = '0;
    bus.addr.code.bank = a[`CODE_AW-1];
    bus.addr.code.word = a[`BANK_AW-1:0];
    bus.dout           = data;
    bus.mem_wr         = 1'b1;
    step();
    bus_idle();
    if (m_unlocked) begin
      code_model[a] = data;
      code_known[a] = 1'b1;
    end
  endtask

  // one new address per cycle, each word checked one edge later
  task automatic code_read_burst(input int n);
    logic [`CODE_AW-1:0] addrs [$];
    int                  i;
    for (i = 0; i < n; i++) begin
      addrs.push_back(written[$urandom_range(written.size() - 1, 0)]);
    end
    code_addr = addrs[0];
    for (i = 0; i < n; i++) begin
      step();
      if (code_known[addrs[i]]) begin
        check_word($sformatf("insn at %h", addrs[i]), insn, code_model[addrs[i]]);
      end
      if (i < n - 1) code_addr = addrs[i + 1];
    end
  endtask

  initial begin
    io_sel_t             sel;
    logic [`CODE_AW-1:0] a;
    void'($urandom(32'h1706));
    errors       = 0;
    test_errors  = 0;
    tests_run    = 0;
    tests_failed = 0;
    resetq       = 1'b0;
    bus          = '0;
    code_addr    = '0;
    uart_rx_data = '0;
    uart_valid   = 1'b0;
    uart_busy    = 1'b0;

    apply_reset();
    check_regs("after reset");
    check_word("uart_wr after reset", word_t'(uart_wr), '0);
    check_word("uart_rd after reset", word_t'(uart_rd), '0);
    finish_test("reset_state");

    repeat (40) begin
      sel          = '0;
      sel.leds     = 1'($urandom);
      sel.pmod_dir = 1'($urandom);
      sel.hdr1_dir = 1'($urandom);
      sel.hdr2_dir = 1'($urandom);
      sel.warmboot = 1'($urandom);
      io_write(sel, word_t'($urandom));
    end
    finish_test("register_writes");

    repeat (40) io_read_check(io_sel_t'(16'($urandom)));
    finish_test("io_reads");

    repeat (20) uart_access(1'($urandom));
    finish_test("uart_strobes");

    repeat (N_CODE_WR) begin
      a = 12'($urandom);
      code_write(a, word_t'($urandom));
      written.push_back(a);
    end
    code_read_burst(N_CODE_RD);
    finish_test("code_memory");

    // runs last so the locked writes land on known words
    apply_reset();
    check_word("unlocked after second reset", word_t'(i_dut.unlocked), '0);
    foreach (written[i]) code_write(written[i], word_t'($urandom));
    code_read_burst(N_CODE_RD);
    finish_test("locked_memory");

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- j1a_bus.sv
`timescale 1ns/10ps
`include "j1a_defs.svh"

module j1a_bus import j1a_pkg::*; (
  input  logic                clk,
  input  logic                resetq,
  input  cpu_bus_t            bus,
  input  logic [`CODE_AW-1:0] code_addr,
  input  logic [`REG_W-1:0]   uart_rx_data,
  input  logic                uart_valid,
  input  logic                uart_busy,
  output word_t               io_rdata,
  output word_t               insn,
  output logic [`LED_W-1:0]   leds,
  output logic [`REG_W-1:0]   pmod_dir,
  output logic [`REG_W-1:0]   hdr1_dir,
  output logic [`REG_W-1:0]   hdr2_dir,
  output logic [`BOOT_W-1:0]  boot_ctl,
  output logic                uart_wr,
  output logic                uart_rd,
  output logic [`REG_W-1:0]   uart_tx
);

  // code memory write enable from the io side
  logic unlocked;

  io_decode i_io_decode (
    .clk          (clk),
    .resetq       (resetq),
    .bus          (bus),
    .uart_rx_data (uart_rx_data),
    .uart_valid   (uart_valid),
    .uart_busy    (uart_busy),
    .io_rdata     (io_rdata),
    .unlocked     (unlocked),
    .leds         (leds),
    .pmod_dir     (pmod_dir),
    .hdr1_dir     (hdr1_dir),
    .hdr2_dir     (hdr2_dir),
    .boot_ctl     (boot_ctl),
    .uart_wr      (uart_wr),
    .uart_rd      (uart_rd),
    .uart_tx      (uart_tx)
  );

  code_ram i_code_ram (
    .clk       (clk),
    .bus       (bus),
    .unlocked  (unlocked),
    .code_addr (code_addr),
    .insn      (insn)
  );

endmodule

//--- io_decode.sv
`timescale 1ns/10ps
`include "j1a_defs.svh"

module io_decode import j1a_pkg::*; (
  input  logic               clk,
  input  logic               resetq,
  input  cpu_bus_t           bus,
  input  logic [`REG_W-1:0]  uart_rx_data,
  input  logic               uart_valid,
  input  logic               uart_busy,
  output word_t              io_rdata,
  output logic               unlocked,
  output logic [`LED_W-1:0]  leds,
  output logic [`REG_W-1:0]  pmod_dir,
  output logic [`REG_W-1:0]  hdr1_dir,
  output logic [`REG_W-1:0]  hdr2_dir,
  output logic [`BOOT_W-1:0] boot_ctl,
  output logic               uart_wr,
  output logic               uart_rd,
  output logic [`REG_W-1:0]  uart_tx
);

  logic    io_rd_q;
  logic    io_wr_q;
  word_t   dout_q;
  io_sel_t sel_q;
  io_sel_t wr_sel;
  word_t   status;

  // io stage, one register level between the cpu and the peripherals
  always_ff @(posedge clk) begin
    if (!resetq) begin
      io_rd_q <= 1'b0;
      io_wr_q <= 1'b0;
    end else begin
      io_rd_q <= bus.io_rd;
      io_wr_q <= bus.io_wr;
    end
  end

  // address is held between accesses so read data stays put
  always_ff @(posedge clk) begin
    dout_q <= bus.dout;
    if (bus.io_rd || bus.io_wr) begin
      sel_q <= bus.addr.io;
    end
  end

  // write decode
  assign wr_sel = io_wr_q ? sel_q : '0;

  always_ff @(posedge clk) begin
    if (!resetq) begin
      leds     <= '0;
      pmod_dir <= '0;
      hdr1_dir <= '0;
      hdr2_dir <= '0;
      boot_ctl <= '0;
    end else begin
      if (wr_sel.leds) begin
        leds <= dout_q[`LED_W-1:0];
      end
      // direction bits, 1 means output
      if (wr_sel.pmod_dir) begin
        pmod_dir <= dout_q[`REG_W-1:0];
      end
      if (wr_sel.hdr1_dir) begin
        hdr1_dir <= dout_q[`REG_W-1:0];
      end
      if (wr_sel.hdr2_dir) begin
        hdr2_dir <= dout_q[`REG_W-1:0];
      end
      if (wr_sel.warmboot) begin
        boot_ctl <= dout_q[`BOOT_W-1:0];
      end
    end
  end

  // any io write opens the code memory until the next reset
  always_ff @(posedge clk) begin
    if (!resetq) begin
      unlocked <= 1'b0;
    end else begin
      unlocked <= unlocked | io_wr_q;
    end
  end

  // uart strobes for the external transceiver
  assign uart_wr = io_wr_q & sel_q.uart;
  assign uart_rd = io_rd_q & sel_q.uart;
  assign uart_tx = dout_q[`REG_W-1:0];

  // bit 0 ready to send, bit 1 byte waiting, bits 2 and 3 always set
  assign status = {{(`WORD_W-4){1'b0}}, 2'b11, uart_valid, ~uart_busy};

  // read-back, every selected source is ORed in
  assign io_rdata =
    (sel_q.pmod_dir ? word_t'(pmod_dir)     : '0) |
    (sel_q.leds     ? word_t'(leds)         : '0) |
    (sel_q.hdr1_dir ? word_t'(hdr1_dir)     : '0) |
    (sel_q.hdr2_dir ? word_t'(hdr2_dir)     : '0) |
    (sel_q.uart     ? word_t'(uart_rx_data) : '0) |
    (sel_q.misc_in  ? status                : '0);

  // the cpu issues at most one io strobe per cycle
  assert property (@(posedge clk) disable iff (!resetq) !(bus.io_rd && bus.io_wr))
    else $error("io_rd and io_wr asserted in the same cycle");

endmodule

//--- code_ram.sv
`timescale 1ns/10ps
`include "j1a_defs.svh"

module code_ram import j1a_pkg::*; (
  input  logic                clk,
  input  cpu_bus_t            bus,
  input  logic                unlocked,
  input  logic [`CODE_AW-1:0] code_addr,
  output word_t               insn
);

  localparam int NBANKS = 2 ** (`CODE_AW - `BANK_AW);

  logic  wr_en;
  logic  bank_q;
  word_t rdata [NBANKS];

  // code stays read-only until the first io write
  assign wr_en = bus.mem_wr && unlocked;

  for (genvar b = 0; b < NBANKS; b++) begin : g_bank
    code_bank i_bank (
      .clk   (clk),
      .raddr (code_addr[`BANK_AW-1:0]),
      .rdata (rdata[b]),
      .we    (wr_en && (bus.addr.code.bank == 1'(b))),
      .waddr (bus.addr.code.word),
      .wdata (bus.dout)
    );
  end

  // bank bit lines up with the registered read data
  always_ff @(posedge clk) begin
    bank_q <= code_addr[`CODE_AW-1];
  end

  assign insn = rdata[bank_q];

  // the cpu writes whole words, so its byte address is always even
  assert property (@(posedge clk) bus.mem_wr |-> !bus.addr.code.byte_sel)
    else $error("code write to an odd byte address");

endmodule

//--- code_bank.sv
`timescale 1ns/10ps
`include "j1a_defs.svh"

module code_bank import j1a_pkg::*; (
  input  logic                clk,
  input  logic [`BANK_AW-1:0] raddr,
  output word_t               rdata,
  input  logic                we,
  input  logic [`BANK_AW-1:0] waddr,
  input  word_t               wdata
);

  localparam int DEPTH = 2 ** `BANK_AW;

  word_t mem [DEPTH];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // registered read, same address as a write returns the old word
  always_ff @(posedge clk) begin
    rdata <= mem[raddr];
  end

endmodule

//--- j1a_pkg.sv
`include "j1a_defs.svh"

package j1a_pkg;

  typedef logic [`WORD_W-1:0] word_t;

  // one-hot io address
  // bits 0, 3, 4 and 6 belonged to the gpio and misc-out ports
  typedef struct packed {
    logic [1:0] spare_hi;
    logic       misc_in;
    logic       uart;
    logic       warmboot;
    logic [2:0] spare_mid;
    logic       hdr2_dir;
    logic       spare_6;
    logic       hdr1_dir;
    logic [1:0] spare_4_3;
    logic       leds;
    logic       pmod_dir;
    logic       spare_0;
  } io_sel_t;

  // cpu byte address seen as a code word address
  typedef struct packed {
    logic [`WORD_W-`BANK_AW-3:0] spare;
    logic                        bank;
    logic [`BANK_AW-1:0]         word;
    logic                        byte_sel;
  } code_waddr_t;

  // io accesses use the select view, code writes the bank and word view
  typedef union packed {
    io_sel_t     io;
    code_waddr_t code;
  } bus_addr_u;

  // strobes, address and write data from the cpu
  typedef struct packed {
    logic      io_rd;
    logic      io_wr;
    logic      mem_wr;
    bus_addr_u addr;
    word_t     dout;
  } cpu_bus_t;

endpackage

//--- j1a_defs.svh
`ifndef J1A_DEFS_SVH
`define J1A_DEFS_SVH

// cpu data word and io address word
`define WORD_W 16

// instruction address, top bit picks the bank
`define CODE_AW 12

// word index inside one code bank
`define BANK_AW 11

// direction registers and uart bytes
`define REG_W 8

`define LED_W 5

// boot, s1, s0
`define BOOT_W 3

`endif
